//--- Bender.yml
package:
  name: lsu

sources:
  - files:
      - design/lsu_pkg.sv
      - design/lsu_request_gen.sv
      - design/lsu_outstanding_ctrl.sv
      - design/lsu_rdata_align.sv
      - design/lsu_top.sv
  - target: test
    files:
      - bench/lsu_mem_model.sv
      - bench/lsu_tb.sv

//--- bench/lsu_cases.txt
# op: 0 load, 1 store; size: 0 byte, 1 half, 2 word; sext: 1 sign-extends a load
# op addr size sext wdata rdata, all hex, rdata unused for stores
0 00000084 0 1 00000000 ffffff84
0 00000084 0 0 00000000 00000084
0 00000086 1 1 00000000 ffff8786
0 00000086 1 0 00000000 00008786
0 00000010 2 0 00000000 13121110
0 00000021 0 0 00000000 00000021
0 00000093 0 1 00000000 ffffff93
0 00000041 2 0 00000000 44434241
0 00000042 2 0 00000000 45444342
0 00000043 2 0 00000000 46454443
0 0000008b 1 1 00000000 ffff8c8b
0 00000045 1 0 00000000 00004645
0 00000097 1 0 00000000 00009897
1 000000c0 2 0 deadbeef 00000000
1 000000c5 0 0 000000a5 00000000
1 000000c6 1 0 00001234 00000000
1 000000cb 1 0 00005678 00000000
1 000000cd 2 0 a1b2c3d4 00000000
1 000000c4 0 0 00000077 00000000
1 000000d2 0 0 00000011 00000000
1 000000d7 0 0 00000022 00000000
1 000000e2 2 0 01020304 00000000
1 000000eb 2 0 0a0b0c0d 00000000
0 000000c0 2 0 00000000 deadbeef
0 000000c4 2 0 00000000 1234a577
0 000000c5 0 1 00000000 ffffffa5
0 000000cb 1 0 00000000 00005678
0 000000cd 2 0 00000000 a1b2c3d4
0 000000ca 2 0 00000000 d45678ca
0 000000cf 1 1 00000000 ffffa1b2
0 000000c2 1 1 00000000 ffffdead
0 000000d4 2 0 00000000 22d6d5d4
0 000000d0 2 0 00000000 d311d1a1
0 000000e0 2 0 00000000 0304e1e0
0 000000e4 2 0 00000000 e7e60102
0 000000e9 2 0 00000000 0c0deae9
0 000000ec 2 0 00000000 ef0a0b0c

//--- bench/lsu_mem_model.sv
// Memory bus responder model
`timescale 1ns/1ps

module lsu_mem_model (
  input  logic                        clk,
  input  logic                        rst_n,
  // Address phase from the LSU
  input  logic                        data_req_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  data_addr_i,
  input  logic                        data_we_i,
  input  logic [lsu_pkg::BE_W-1:0]    data_be_i,
  input  logic [lsu_pkg::DATA_W-1:0]  data_wdata_i,
  output logic                        data_gnt_o,
  // In-order responses
  output logic                        data_rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0]  data_rdata_o
);

  import lsu_pkg::*;

  localparam int          MEM_WORDS = 64;
  localparam logic [31:0] LFSR_SEED = 32'hc09514a1;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [31:0]       lfsr;
  logic [5:0]        idx;
  int                grant_wait;
  int                rsp_delay;
  int                cycle;
  // Pending responses with the cycle each one may leave
  logic [DATA_W-1:0] rsp_data_q [$];
  int                rsp_due_q  [$];

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // Each byte holds its own address
  initial begin
    for (int w = 0; w < MEM_WORDS; w++) begin
      for (int b = 0; b < BE_W; b++) begin
        mem[w][8*b +: 8] = 8'(4*w + b);
      end
    end
    lfsr          = LFSR_SEED;
    grant_wait    = 0;
    cycle         = 0;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_gnt_o    <= 1'b0;
      data_rvalid_o <= 1'b0;
      data_rdata_o  <= '0;
    end else begin
      ////////////////////////////////////////////////////////////////////
      // Address phase, grant after 0 to 3 idle cycles
      ////////////////////////////////////////////////////////////////////
      if (data_req_i && data_gnt_o) begin
        idx = data_addr_i[7:2];
        if (data_we_i) begin
          for (int b = 0; b < BE_W; b++) begin
            if (data_be_i[b]) mem[idx][8*b +: 8] = data_wdata_i[8*b +: 8];
          end
        end
        // Response 1 to 4 cycles after the grant
        draw_bits(2, rsp_delay);
        rsp_data_q.push_back(mem[idx]);
        rsp_due_q.push_back(cycle + rsp_delay);
        data_gnt_o <= 1'b0;
        draw_bits(2, grant_wait);
      end else if (data_req_i && (grant_wait == 0)) begin
        data_gnt_o <= 1'b1;
      end else begin
        if (data_req_i) grant_wait--;
        data_gnt_o <= 1'b0;
      end
      ////////////////////////////////////////////////////////////////////
      // Response phase, strictly in order
      ////////////////////////////////////////////////////////////////////
      if ((rsp_due_q.size() != 0) && (rsp_due_q[0] <= cycle)) begin
        data_rvalid_o <= 1'b1;
        data_rdata_o  <= rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        data_rvalid_o <= 1'b0;
      end
      cycle++;
    end
  end

endmodule

//--- bench/lsu_tb.sv
// Load/store unit testbench
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int WAIT_LIMIT = 64;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic [ADDR_W-1:0] req_addr;
  logic              req_we;
  lsu_size_e         req_size;
  logic              req_sext;
  logic [DATA_W-1:0] req_wdata;
  logic              req_ready;
  logic              data_req;
  logic [ADDR_W-1:0] data_addr;
  logic              data_we;
  logic [BE_W-1:0]   data_be;
  logic [DATA_W-1:0] data_wdata;
  logic              data_gnt;
  logic              data_rvalid;
  logic [DATA_W-1:0] data_rdata;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_rdata;
  logic              busy;

  // Accesses as read from the case file
  logic              case_we    [$];
  logic [ADDR_W-1:0] case_addr  [$];
  lsu_size_e         case_size  [$];
  logic              case_sext  [$];
  logic [DATA_W-1:0] case_wdata [$];
  logic [DATA_W-1:0] case_rdata [$];
  // Expected bus transfers in issue order
  logic [ADDR_W-1:0] xfer_addr_q  [$];
  logic [BE_W-1:0]   xfer_be_q    [$];
  logic              xfer_last_q  [$];
  lsu_size_e         xfer_size_q  [$];
  logic              xfer_we_q    [$];
  logic [DATA_W-1:0] xfer_wdata_q [$];
  int                access_bytes = 0;

  lsu_top UUT (
    .clk (clk), .rst_n (rst_n),
    .req_valid_i (req_valid), .req_addr_i (req_addr), .req_we_i (req_we),
    .req_size_i (req_size), .req_sext_i (req_sext), .req_wdata_i (req_wdata),
    .req_ready_o (req_ready),
    .data_req_o (data_req), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_gnt_i (data_gnt),
    .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata),
    .rsp_valid_o (rsp_valid), .rsp_rdata_o (rsp_rdata), .busy_o (busy)
  );

  lsu_mem_model u_mem (
    .clk (clk), .rst_n (rst_n),
    .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
    .data_be_i (data_be), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
    .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling and compares
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_be(input string name, input logic [BE_W-1:0] got, exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_size(input string name, input lsu_size_e got, exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Lanes of the word at word_addr that the access touches
  function automatic logic [BE_W-1:0] lanes_in_word(logic [ADDR_W-1:0] addr, int nbytes,
                                                    logic [ADDR_W-1:0] word_addr);
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] a;
    be = '0;
    for (int k = 0; k < nbytes; k++) begin
      a = addr + ADDR_W'(k);
      if (a[ADDR_W-1:2] == word_addr[ADDR_W-1:2]) be[a[1:0]] = 1'b1;
    end
    return be;
  endfunction

  // Store bytes placed in the lanes of the word at word_addr
  function automatic logic [DATA_W-1:0] lane_data(logic [ADDR_W-1:0] addr, int nbytes,
                                                  logic [DATA_W-1:0] wdata,
                                                  logic [ADDR_W-1:0] word_addr);
    logic [DATA_W-1:0] d;
    logic [ADDR_W-1:0] a;
    d = '0;
    for (int k = 0; k < nbytes; k++) begin
      a = addr + ADDR_W'(k);
      if (a[ADDR_W-1:2] == word_addr[ADDR_W-1:2]) d[8*a[1:0] +: 8] = wdata[8*k +: 8];
    end
    return d;
  endfunction

  // Byte enables widened to a bit mask
  function automatic logic [DATA_W-1:0] be_mask(logic [BE_W-1:0] be);
    logic [DATA_W-1:0] m;
    m = '0;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) m[8*b +: 8] = 8'hff;
    end
    return m;
  endfunction

  function automatic lsu_size_e size_from_bytes(int n);
    case (n)
      1:       return SIZE_BYTE;
      2:       return SIZE_HALF;
      4:       return SIZE_WORD;
      default: return lsu_size_e'(2'b11);
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Case file and expected transfers
  //////////////////////////////////////////////////////////////////////

  task automatic load_cases();
    int                fd;
    int                n;
    string             line;
    logic [31:0]       op, addr, size, sext, wdata, rdata;
    logic [ADDR_W-1:0] next_word;
    logic [BE_W-1:0]   be_lo, be_hi;
    fd = $fopen("bench/lsu_cases.txt", "r");
    if (fd == 0) begin
      $display("The case file bench/lsu_cases.txt could not be opened");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0) break;
      if ((line.len() < 2) || (line.getc(0) == "#")) continue;
      n = $sscanf(line, "%h %h %h %h %h %h", op, addr, size, sext, wdata, rdata);
      if (n != 6) continue;
      case_we.push_back(op[0]);
      case_addr.push_back(addr);
      case_size.push_back(lsu_size_e'(size[1:0]));
      case_sext.push_back(sext[0]);
      case_wdata.push_back(wdata);
      case_rdata.push_back(rdata);
      // Bytes past the end of the word go to the next word
      next_word = {addr[ADDR_W-1:2], 2'b00} + ADDR_W'(4);
      be_lo     = lanes_in_word(addr, 1 << size[1:0], addr);
      be_hi     = lanes_in_word(addr, 1 << size[1:0], next_word);
      xfer_addr_q.push_back(addr);
      xfer_be_q.push_back(be_lo);
      xfer_last_q.push_back(be_hi == '0);
      xfer_size_q.push_back(lsu_size_e'(size[1:0]));
      xfer_we_q.push_back(op[0]);
      xfer_wdata_q.push_back(lane_data(addr, 1 << size[1:0], wdata, addr));
      if (be_hi != '0) begin
        xfer_addr_q.push_back(next_word);
        xfer_be_q.push_back(be_hi);
        xfer_last_q.push_back(1'b1);
        xfer_size_q.push_back(lsu_size_e'(size[1:0]));
        xfer_we_q.push_back(op[0]);
        xfer_wdata_q.push_back(lane_data(addr, 1 << size[1:0], wdata, next_word));
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and response checking
  //////////////////////////////////////////////////////////////////////

  // Next access goes out on the same edge the last one is accepted
  task automatic issue_all();
    int waited;
    for (int i = 0; i < case_addr.size(); i++) begin
      req_valid <= 1'b1;
      req_addr  <= case_addr[i];
      req_we    <= case_we[i];
      req_size  <= case_size[i];
      req_sext  <= case_sext[i];
      req_wdata <= case_wdata[i];
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout: case %0d was never accepted by the LSU", i);
          abort_run();
        end
      end while (!req_ready);
    end
    req_valid <= 1'b0;
  endtask

  // Results come back in issue order, store results carry no data
  task automatic check_responses();
    int waited;
    for (int i = 0; i < case_addr.size(); i++) begin
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout: no result came back for case %0d", i);
          abort_run();
        end
      end while (!rsp_valid);
      if (!case_we[i]) check_data("rsp_rdata_o", rsp_rdata, case_rdata[i]);
    end
  endtask

  // Bus monitor, one expected entry per granted transfer
  always @(posedge clk) begin
    if (rst_n && data_req && data_gnt) begin
      if (xfer_addr_q.size() == 0) begin
        $display("A bus transfer was granted with no access left to match it");
        abort_run();
      end else begin
        check_addr("data_addr_o", data_addr, xfer_addr_q[0]);
        check_be("data_be_o", data_be, xfer_be_q[0]);
        check_bit("data_we_o", data_we, xfer_we_q[0]);
        // Only enabled lanes of a store carry data
        if (xfer_we_q[0]) begin
          check_data("data_wdata_o", data_wdata & be_mask(xfer_be_q[0]),
                     xfer_wdata_q[0]);
        end
        access_bytes += $countones(data_be);
        // Enables over all transfers of one access cover its size
        if (xfer_last_q[0]) begin
          check_size("size from data_be_o", size_from_bytes(access_bytes), xfer_size_q[0]);
          access_bytes = 0;
        end
        void'(xfer_addr_q.pop_front());
        void'(xfer_be_q.pop_front());
        void'(xfer_last_q.pop_front());
        void'(xfer_size_q.pop_front());
        void'(xfer_we_q.pop_front());
        void'(xfer_wdata_q.pop_front());
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_size  = SIZE_BYTE;
    req_sext  = 1'b0;
    req_wdata = '0;
    load_cases();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    fork
      issue_all();
      check_responses();
    join
    // Counter drops on the edge of the last response
    @(posedge clk);
    if (!busy && (xfer_addr_q.size() == 0)) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("LSU still busy or bus transfers missing after the last result");
      abort_run();
    end
  end

endmodule

//--- design/lsu_outstanding_ctrl.sv
// LSU outstanding transfer control
`timescale 1ns/1ps

module lsu_outstanding_ctrl (
  input  logic clk,
  input  logic rst_n,
  // Address phase handshake
  input  logic addr_phase_valid_i,
  output logic addr_phase_ready_o,
  // Bus events
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  // Pending core request
  input  logic req_valid_i,
  output logic busy_o
);

  import lsu_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             count_up;
  logic             count_down;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  // Block new address phases once the window is full
  assign addr_phase_ready_o = (cnt_q != CNT_W'(LSU_DEPTH));

  // Up on an accepted address phase, down on each response
  assign count_up   = addr_phase_valid_i && addr_phase_ready_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + CNT_W'(1);
      2'b01:   cnt_d = cnt_q - CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Busy from request arrival until the last response returns
  assign busy_o = req_valid_i || (cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_W'(LSU_DEPTH));

  // Responses only for transfers granted in an earlier cycle
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

endmodule

//--- design/lsu_pkg.sv
// Load/store unit shared definitions

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Byte address and data word widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;

  // One enable per byte lane
  localparam int BE_W      = DATA_W / 8;

  // Outstanding bus transfers, shared by counter and info queue
  localparam int LSU_DEPTH = 2;

  // Holds 0 to LSU_DEPTH
  localparam int CNT_W     = $clog2(LSU_DEPTH + 1);

  // Index into the info queue
  localparam int PTR_W     = $clog2(LSU_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Access size as driven by the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Address phase of a possibly split access
  typedef enum logic {
    PHASE_FIRST  = 1'b0,
    PHASE_SECOND = 1'b1
  } lsu_phase_e;

endpackage

//--- design/lsu_rdata_align.sv
// LSU read data alignment
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                        clk,
  input  logic                        rst_n,
  // Info of the granted transfer
  input  logic                        push_i,
  input  lsu_pkg::lsu_size_e          push_size_i,
  input  logic                        push_sext_i,
  input  logic [1:0]                  push_offset_i,
  input  logic                        push_last_i,
  input  logic                        push_we_i,
  // Bus response
  input  logic                        data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]  data_rdata_i,
  // Result to write-back
  output logic                        rsp_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]  rsp_rdata_o
);

  import lsu_pkg::*;

  // Info queue storage
  lsu_size_e          q_size   [LSU_DEPTH];
  logic               q_sext   [LSU_DEPTH];
  logic [1:0]         q_offset [LSU_DEPTH];
  logic               q_last   [LSU_DEPTH];
  logic               q_we     [LSU_DEPTH];

  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   q_cnt_q;

  // Head entry, belongs to the response now on the bus
  lsu_size_e          head_size;
  logic               head_sext;
  logic [1:0]         head_offset;
  logic               head_last;
  logic               head_split;

  logic [DATA_W-1:0]  rdata_q;
  logic [2*DATA_W-1:0] rdata_full;
  logic [2*DATA_W-1:0] rdata_shift;

  //////////////////////////////////////////////////////////////////////
  // In-order info queue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push_i) begin
      q_size[wr_ptr_q]   <= push_size_i;
      q_sext[wr_ptr_q]   <= push_sext_i;
      q_offset[wr_ptr_q] <= push_offset_i;
      q_last[wr_ptr_q]   <= push_last_i;
      q_we[wr_ptr_q]     <= push_we_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      q_cnt_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (data_rvalid_i) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      q_cnt_q <= q_cnt_q + CNT_W'(push_i) - CNT_W'(data_rvalid_i);
    end
  end

  assign head_size   = q_size[rd_ptr_q];
  assign head_sext   = q_sext[rd_ptr_q];
  assign head_offset = q_offset[rd_ptr_q];
  assign head_last   = q_last[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Realignment and extension
  //////////////////////////////////////////////////////////////////////

  // Low half of a split load waits here for the upper word
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !head_last && !q_we[rd_ptr_q]) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign head_split = ((head_size == SIZE_WORD) && (head_offset != 2'b00)) ||
                      ((head_size == SIZE_HALF) && (head_offset == 2'b11));

  // Unsplit accesses wrap the word onto itself for the shift
  assign rdata_full  = head_split ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};
  assign rdata_shift = rdata_full >> {head_offset, 3'b000};

  always_comb begin
    case (head_size)
      SIZE_BYTE: rsp_rdata_o = {{24{head_sext && rdata_shift[7]}},  rdata_shift[7:0]};
      SIZE_HALF: rsp_rdata_o = {{16{head_sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:   rsp_rdata_o = rdata_shift[DATA_W-1:0];
    endcase
  end

  // One pulse per access, on its final response
  assign rsp_valid_o = data_rvalid_i && head_last;

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (q_cnt_q != CNT_W'(LSU_DEPTH)));

endmodule

//--- design/lsu_request_gen.sv
// LSU address phase generation
`timescale 1ns/1ps

module lsu_request_gen (
  input  logic                        clk,
  input  logic                        rst_n,
  // Core request
  input  logic                        req_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic                        req_we_i,
  input  lsu_pkg::lsu_size_e          req_size_i,
  input  logic [lsu_pkg::DATA_W-1:0]  req_wdata_i,
  output logic                        req_ready_o,
  // Handshake with the outstanding counter
  output logic                        addr_phase_valid_o,
  input  logic                        addr_phase_ready_i,
  // Memory bus address phase
  output logic                        data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0]  data_addr_o,
  output logic                        data_we_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]  data_wdata_o,
  input  logic                        data_gnt_i,
  // Transfer info for the read path
  output logic                        split_o,
  output logic [1:0]                  offset_o
);

  import lsu_pkg::*;

  lsu_phase_e         phase_q;
  logic [1:0]         offset;
  logic               gnt;
  logic [BE_W-1:0]    be;
  logic [DATA_W-1:0]  wdata_rot;

  assign offset   = req_addr_i[1:0];
  assign offset_o = offset;

  //////////////////////////////////////////////////////////////////////
  // Split detection
  //////////////////////////////////////////////////////////////////////

  // Only the first phase can split; words at any nonzero offset,
  // halfwords only when they cross into the next word
  always_comb begin
    split_o = 1'b0;
    if (req_valid_i && (phase_q == PHASE_FIRST)) begin
      case (req_size_i)
        SIZE_WORD: split_o = (offset != 2'b00);
        SIZE_HALF: split_o = (offset == 2'b11);
        default:   split_o = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    be = '0;
    case (req_size_i)
      SIZE_BYTE: be = BE_W'(4'b0001 << offset);
      SIZE_HALF: begin
        if (phase_q == PHASE_FIRST) begin
          // Offset 3 keeps only the top lane here
          case (offset)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          be = 4'b0001;
        end
      end
      default: begin
        if (phase_q == PHASE_FIRST) begin
          case (offset)
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Remaining low lanes of the next word
          case (offset)
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            2'b11:   be = 4'b0111;
            default: be = 4'b0000;
          endcase
        end
      end
    endcase
  end

  // Rotate left by the byte offset, so each byte lands in its lane
  always_comb begin
    case (offset)
      2'b01:   wdata_rot = {req_wdata_i[23:0], req_wdata_i[31:24]};
      2'b10:   wdata_rot = {req_wdata_i[15:0], req_wdata_i[31:16]};
      2'b11:   wdata_rot = {req_wdata_i[7:0],  req_wdata_i[31:8]};
      default: wdata_rot = req_wdata_i;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Bus request and phase tracking
  //////////////////////////////////////////////////////////////////////

  assign addr_phase_valid_o = req_valid_i;
  assign data_req_o         = req_valid_i && addr_phase_ready_i;
  assign gnt                = data_req_o && data_gnt_i;

  // Second phase goes to the next word, starting at lane 0
  assign data_addr_o  = (phase_q == PHASE_SECOND) ?
                        ({req_addr_i[ADDR_W-1:2], 2'b00} + ADDR_W'(4)) : req_addr_i;
  assign data_we_o    = req_we_i;
  assign data_be_o    = be;
  assign data_wdata_o = wdata_rot;

  // Core sees ready only on the final grant of the access
  assign req_ready_o  = gnt && !split_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PHASE_FIRST;
    end else if (!req_valid_i) begin
      phase_q <= PHASE_FIRST;
    end else if (gnt) begin
      phase_q <= split_o ? PHASE_SECOND : PHASE_FIRST;
    end
  end

  // Every issued transfer touches at least one lane
  a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> (data_be_o != '0));

  // A pending request keeps its address until granted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o)));

endmodule

//--- design/lsu_top.sv
// Load/store unit top level
`timescale 1ns/1ps

module lsu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // Core request
  input  logic                        req_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic                        req_we_i,
  input  lsu_pkg::lsu_size_e          req_size_i,
  input  logic                        req_sext_i,
  input  logic [lsu_pkg::DATA_W-1:0]  req_wdata_i,
  output logic                        req_ready_o,
  // Memory bus
  output logic                        data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0]  data_addr_o,
  output logic                        data_we_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]  data_wdata_o,
  input  logic                        data_gnt_i,
  input  logic                        data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]  data_rdata_i,
  // Result
  output logic                        rsp_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]  rsp_rdata_o,
  output logic                        busy_o
);

  logic       addr_phase_valid;
  logic       addr_phase_ready;
  logic       split;
  logic [1:0] offset;
  logic       push;
  logic       push_last;

  // Transfer info is pushed on every grant
  assign push      = data_req_o && data_gnt_i;
  assign push_last = !split;

  lsu_request_gen u_request_gen (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_valid_i        (req_valid_i),
    .req_addr_i         (req_addr_i),
    .req_we_i           (req_we_i),
    .req_size_i         (req_size_i),
    .req_wdata_i        (req_wdata_i),
    .req_ready_o        (req_ready_o),
    .addr_phase_valid_o (addr_phase_valid),
    .addr_phase_ready_i (addr_phase_ready),
    .data_req_o         (data_req_o),
    .data_addr_o        (data_addr_o),
    .data_we_o          (data_we_o),
    .data_be_o          (data_be_o),
    .data_wdata_o       (data_wdata_o),
    .data_gnt_i         (data_gnt_i),
    .split_o            (split),
    .offset_o           (offset)
  );

  lsu_outstanding_ctrl u_outstanding_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .addr_phase_valid_i (addr_phase_valid),
    .addr_phase_ready_o (addr_phase_ready),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .req_valid_i        (req_valid_i),
    .busy_o             (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (push),
    .push_size_i   (req_size_i),
    .push_sext_i   (req_sext_i),
    .push_offset_i (offset),
    .push_last_i   (push_last),
    .push_we_i     (req_we_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o)
  );

endmodule

//--- lsu_top.f
design/lsu_pkg.sv
design/lsu_request_gen.sv
design/lsu_outstanding_ctrl.sv
design/lsu_rdata_align.sv
design/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv
